/* rtl/demodPkg.sv */
// Address map, version word, widths, source and mode enums, bus and sample structs
`default_nettype none

package demodPkg;

  // ************************************************
  // Widths
  // ************************************************
  localparam int AddrW       = 12;
  localparam int DataW       = 16;
  localparam int TrellisW    = 18;
  localparam int DacW        = 14;
  localparam int PhErrW      = 8;
  localparam int DacChannels = 3;

  // ************************************************
  // Misc register space
  // ************************************************
  localparam logic [DataW-1:0] VerNumber       = 16'h010e;
  localparam logic [AddrW-1:0] MiscResetAddr   = 12'h000;  // Write requests a soft reset
  localparam logic [AddrW-1:0] MiscVersionAddr = 12'h002;  // Read-only version word

  // Extra cycles the core reset stays up after the request
  localparam logic [2:0] ResetHold = 3'd5;

  // Offset-binary zero on the DAC pins
  localparam logic [DacW-1:0] DacMidScale = 14'h2000;

  // ************************************************
  // Encodings
  // ************************************************
  // Unlisted codes behave as legacy
  typedef enum logic [3:0] {
    ModeLegacy = 4'h0,
    ModeMultiH = 4'h8
  } demodMode_e;

  // Codes 1 to 4 are the trellis group
  typedef enum logic [3:0] {
    DacDirect       = 4'h0,
    DacTrellisI     = 4'h1,
    DacTrellisQ     = 4'h2,
    DacTrellisPhErr = 4'h3,
    DacTrellisIndex = 4'h4
  } dacSource_e;

  // ************************************************
  // Bundles
  // ************************************************
  typedef struct packed {
    logic             wrStb;
    logic             rdStb;
    logic [AddrW-1:0] addr;
    logic [DataW-1:0] wrData;
  } hostReq_t;

  typedef struct packed {
    logic                sync;   // Sample valid for the DAC
    logic [TrellisW-1:0] data;
  } trellisSample_t;

  typedef struct packed {
    logic symEn;
    logic sym2xEn;
    logic iBit;
    logic qBit;
  } decSymbol_t;

endpackage

`default_nettype wire

/* rtl/hostRegs.sv */
// Host register port with misc space decode, version readback and soft-reset strobe
`timescale 1ns/1ns
`default_nettype none

module hostRegs (
  input  logic                       ck933,
  input  logic                       rs,
  input  logic                       coreReset_i,
  input  demodPkg::hostReq_t         hostReq_i,
  output logic [demodPkg::DataW-1:0] rdData_o,
  output logic                       rdValid_o,
  output logic                       softReset_o
);
  import demodPkg::*;

  logic             miscSpace;    // Address inside the misc block
  logic [DataW-1:0] miscRdWord;
  logic             resetHit;

  // ************************************************
  // Address decode
  // ************************************************
  // Misc block covers the lowest four byte addresses
  assign miscSpace = (hostReq_i.addr[AddrW-1:2] == '0);

  always_comb begin
    miscRdWord = '0;
    if (miscSpace) begin
      case (hostReq_i.addr)
        MiscVersionAddr: miscRdWord = VerNumber;
        default:         miscRdWord = '0;  // Reset address reads back zero
      endcase
    end
  end

  // Any data word triggers the reset
  // No new request while the core is already held
  assign resetHit = hostReq_i.wrStb && miscSpace
                    && (hostReq_i.addr == MiscResetAddr) && !coreReset_i;

  // ************************************************
  // Read return and reset strobe
  // ************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      rdValid_o   <= 1'b0;
      softReset_o <= 1'b0;
    end else begin
      rdValid_o   <= hostReq_i.rdStb;   // Single-cycle return
      softReset_o <= resetHit;
    end
  end

  always_ff @(posedge ck933) begin
    if (hostReq_i.rdStb) begin
      rdData_o <= miscRdWord;
    end
  end

  // Bus master never issues both strobes in one cycle
  strobeExclusive: assert property (
    @(posedge ck933) disable iff (rs)
    !(hostReq_i.wrStb && hostReq_i.rdStb)
  ) else $error("host read and write strobes high together");

endmodule

`default_nettype wire

/* rtl/resetStretch.sv */
// Soft-reset synchronizer and hold counter producing the core reset
`timescale 1ns/1ns
`default_nettype none

module resetStretch (
  input  logic ck933,
  input  logic rs,
  input  logic softReset_i,
  output logic coreReset_o
);
  import demodPkg::*;

  logic       reqMeta;   // First sync stage
  logic       reqSync;   // Second sync stage
  logic [2:0] holdCnt;

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      reqMeta <= 1'b0;
      reqSync <= 1'b1;       // Board reset acts as a pending request
      holdCnt <= ResetHold;
    end else begin
      reqMeta <= softReset_i;
      reqSync <= reqMeta;
      if (reqSync) begin
        holdCnt <= ResetHold;   // Reload on every request
      end else if (holdCnt != '0) begin
        holdCnt <= holdCnt - 3'd1;
      end
    end
  end

  // High with the synced request, then for the count
  assign coreReset_o = reqSync || (holdCnt != '0);

  // Request pulse gives six cycles of core reset after the sync
  stretchLength: assert property (
    @(posedge ck933) disable iff (rs)
    softReset_i |-> ##2 coreReset_o [*6]
  ) else $error("core reset shorter than six cycles after soft reset");

endmodule

`default_nettype wire

/* rtl/dacChannel.sv */
// One DAC channel with source select, truncation, sign inversion and sync-gated load
`timescale 1ns/1ns
`default_nettype none

module dacChannel (
  input  logic                      ck933,
  input  logic                      rs,
  input  logic                      coreReset_i,
  input  demodPkg::demodMode_e      mode_i,
  input  demodPkg::dacSource_e      select_i,
  input  demodPkg::trellisSample_t  trellis_i,
  input  logic [demodPkg::DacW-1:0] direct_i,
  output logic [demodPkg::DacW-1:0] dac_o
);
  import demodPkg::*;

  logic            trellisSrc;   // Select is in the trellis group
  logic            useTrellis;
  logic [DacW-1:0] pickWord;
  logic            pickEn;
  logic [DacW-1:0] stageWord;
  logic            stageEn;

  // ************************************************
  // Source rule
  // ************************************************
  always_comb begin
    case (select_i)
      DacTrellisI,
      DacTrellisQ,
      DacTrellisPhErr,
      DacTrellisIndex: trellisSrc = 1'b1;
      default:         trellisSrc = 1'b0;
    endcase
  end

  assign useTrellis = trellisSrc && (mode_i == ModeMultiH);

  // Top 14 of the 18 trellis bits
  assign pickWord = useTrellis ? trellis_i.data[TrellisW-1 -: DacW] : direct_i;
  assign pickEn   = useTrellis ? trellis_i.sync : 1'b1;   // Direct loads every cycle

  // ************************************************
  // Stage 2 and output register
  // ************************************************
  always_ff @(posedge ck933) begin
    stageWord <= pickWord;
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      stageEn <= 1'b0;
      dac_o   <= DacMidScale;
    end else if (coreReset_i) begin
      stageEn <= 1'b0;
      dac_o   <= DacMidScale;
    end else begin
      stageEn <= pickEn;
      // Offset binary for the converter
      if (stageEn) begin
        dac_o <= {~stageWord[DacW-1], stageWord[DacW-2:0]};
      end
    end
  end

  dacKnown: assert property (
    @(posedge ck933) disable iff (rs || coreReset_i)
    !$isunknown(dac_o)
  ) else $error("DAC output has unknown bits");

endmodule

`default_nettype wire

/* rtl/decoderInSel.sv */
// Legacy symbol delay and trellis/legacy selection into the decoder input register
`timescale 1ns/1ns
`default_nettype none

module decoderInSel (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   coreReset_i,
  input  demodPkg::demodMode_e   mode_i,
  input  demodPkg::decSymbol_t   trellisSym_i,
  input  demodPkg::decSymbol_t   legacySym_i,
  output demodPkg::decSymbol_t   decSym_o
);
  import demodPkg::*;

  decSymbol_t legacyQ;   // Extra board-path stage
  logic       multiH;

  assign multiH = (mode_i == ModeMultiH);

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      legacyQ  <= '0;
      decSym_o <= '0;
    end else if (coreReset_i) begin
      legacyQ  <= '0;
      decSym_o <= '0;
    end else begin
      legacyQ <= legacySym_i;
      // Trellis decisions only in multi-h mode
      if (multiH) begin
        decSym_o <= trellisSym_i;
      end else begin
        decSym_o <= legacyQ;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/multihTop.sv */
// Multi-h demodulator board glue top with input and phase-error re-registering
`timescale 1ns/1ns
`default_nettype none

module multihTop (
  input  logic                          ck933,
  input  logic                          rs,
  input  demodPkg::hostReq_t            hostReq_i,
  input  demodPkg::demodMode_e          demodMode_i,
  input  demodPkg::dacSource_e          dac0Select_i,
  input  demodPkg::dacSource_e          dac1Select_i,
  input  demodPkg::dacSource_e          dac2Select_i,
  input  logic [demodPkg::DacW-1:0]     dac0Data_i,
  input  logic [demodPkg::DacW-1:0]     dac1Data_i,
  input  logic [demodPkg::DacW-1:0]     dac2Data_i,
  input  demodPkg::trellisSample_t      trellis0_i,
  input  demodPkg::trellisSample_t      trellis1_i,
  input  demodPkg::trellisSample_t      trellis2_i,
  input  demodPkg::decSymbol_t          trellisSym_i,
  input  demodPkg::decSymbol_t          legacySym_i,
  input  logic [demodPkg::PhErrW-1:0]   phaseErr_i,
  input  logic                          phaseErrEn_i,
  input  logic                          phaseErrValid_i,
  output logic [demodPkg::DataW-1:0]    rdData_o,
  output logic                          rdValid_o,
  output logic                          dacRst_o,
  output logic [demodPkg::DacW-1:0]     dac0_o,
  output logic [demodPkg::DacW-1:0]     dac1_o,
  output logic [demodPkg::DacW-1:0]     dac2_o,
  output demodPkg::decSymbol_t          decSym_o,
  output logic [demodPkg::PhErrW-1:0]   phaseErr_o,
  output logic                          phaseErrEn_o,
  output logic                          phaseErrValid_o
);
  import demodPkg::*;

  demodMode_e      modeQ;
  dacSource_e      selQ     [DacChannels];
  logic [DacW-1:0] directQ  [DacChannels];
  trellisSample_t  trellisQ [DacChannels];
  logic [DacW-1:0] dacOut   [DacChannels];
  decSymbol_t      trellisSymQ;
  decSymbol_t      legacySymQ;
  logic            softReset;
  logic            coreReset;

  // ************************************************
  // Input re-registering
  // ************************************************
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      modeQ <= ModeLegacy;
      for (int i = 0; i < DacChannels; i++) begin
        selQ[i] <= DacDirect;
      end
    end else begin
      modeQ   <= demodMode_i;
      selQ[0] <= dac0Select_i;
      selQ[1] <= dac1Select_i;
      selQ[2] <= dac2Select_i;
    end
  end

  always_ff @(posedge ck933) begin
    directQ[0]  <= dac0Data_i;
    directQ[1]  <= dac1Data_i;
    directQ[2]  <= dac2Data_i;
    trellisQ[0] <= trellis0_i;
    trellisQ[1] <= trellis1_i;
    trellisQ[2] <= trellis2_i;
    trellisSymQ <= trellisSym_i;
    legacySymQ  <= legacySym_i;
  end

  // ************************************************
  // Host port and reset
  // ************************************************
  hostRegs i_hostRegs (
    .ck933       (ck933),
    .rs          (rs),
    .coreReset_i (coreReset),
    .hostReq_i   (hostReq_i),
    .rdData_o    (rdData_o),
    .rdValid_o   (rdValid_o),
    .softReset_o (softReset)
  );

  resetStretch i_resetStretch (
    .ck933       (ck933),
    .rs          (rs),
    .softReset_i (softReset),
    .coreReset_o (coreReset)
  );

  assign dacRst_o = coreReset;   // DAC pin follows the core reset

  // ************************************************
  // DAC outputs
  // ************************************************
  for (genvar gi = 0; gi < DacChannels; gi++) begin : g_dac
    dacChannel i_dacChannel (
      .ck933       (ck933),
      .rs          (rs),
      .coreReset_i (coreReset),
      .mode_i      (modeQ),
      .select_i    (selQ[gi]),
      .trellis_i   (trellisQ[gi]),
      .direct_i    (directQ[gi]),
      .dac_o       (dacOut[gi])
    );
  end

  assign dac0_o = dacOut[0];
  assign dac1_o = dacOut[1];
  assign dac2_o = dacOut[2];

  // ************************************************
  // Decoder input and phase error
  // ************************************************
  decoderInSel i_decoderInSel (
    .ck933        (ck933),
    .rs           (rs),
    .coreReset_i  (coreReset),
    .mode_i       (modeQ),
    .trellisSym_i (trellisSymQ),
    .legacySym_i  (legacySymQ),
    .decSym_o     (decSym_o)
  );

  // Phase-error feedback toward the carrier loop
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      phaseErrEn_o    <= 1'b0;
      phaseErrValid_o <= 1'b0;
    end else begin
      phaseErrEn_o    <= phaseErrEn_i;
      phaseErrValid_o <= phaseErrValid_i;
    end
  end

  always_ff @(posedge ck933) begin
    phaseErr_o <= phaseErr_i;
  end

endmodule

`default_nettype wire

/* verif/multihChecker.sv */
// Output checker with a cycle model of the host port, reset stretch, DACs, decoder and phase error
`timescale 1ns/1ns
`default_nettype none

module multihChecker (
  input  logic                             ck933,
  input  logic                             rs,
  input  demodPkg::hostReq_t               hostReq_i,
  input  logic [3:0]                       mode_i,
  input  logic [2:0][3:0]                  sel_i,
  input  logic [2:0][demodPkg::DacW-1:0]   direct_i,
  input  logic [2:0][demodPkg::TrellisW:0] trellis_i,    // {sync, data}
  input  logic [3:0]                       trellisSym_i,
  input  logic [3:0]                       legacySym_i,
  input  logic [9:0]                       phErrIn_i,    // {en, valid, error}
  input  logic                             rdArm_i,
  input  logic [demodPkg::DataW-1:0]       rdExpect_i,
  input  logic [demodPkg::DataW-1:0]       rdData_i,
  input  logic                             rdValid_i,
  input  logic                             dacRst_i,
  input  logic [2:0][demodPkg::DacW-1:0]   dac_i,
  input  logic [3:0]                       decSym_i,
  input  logic [9:0]                       phErrOut_i,
  output int                               errCount_o,
  output int                               checkCount_o
);
  import demodPkg::*;

  typedef struct packed {
    logic                   rsIn;
    logic                   rst;      // Board or core reset
    logic [3:0]             mode;
    logic [2:0][3:0]        sel;
    logic [2:0][DacW-1:0]   direct;
    logic [2:0][TrellisW:0] trellis;
    logic [3:0]             tSym;
    logic [3:0]             lSym;
    logic                   rdStb;
    logic [AddrW-1:0]       addr;
    logic                   arm;
    logic [DataW-1:0]       rdExp;
    logic [9:0]             phErr;
  } snap_t;

  snap_t           hist [0:3];    // Index is the age in cycles
  logic [DacW-1:0] expDac [0:2];
  logic [7:0]      hitPipe;       // Soft-reset writes, bit k is k+1 cycles old
  int              rsLeft;

  initial begin
    errCount_o   = 0;
    checkCount_o = 0;
  end

  function automatic logic [DacW-1:0] offsetBinary(input logic [DacW-1:0] w);
    return {~w[DacW-1], w[DacW-2:0]};
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checkCount_o++;
    if (got !== exp) begin
      errCount_o++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // ************************************************
  // Sample at the rising edge, compare, then age
  // ************************************************
  always @(posedge ck933) begin : sampleCompare
    logic expRst;
    logic trellisPath;
    logic [3:0] expSym;
    for (int k = 3; k > 0; k--) begin
      hist[k] = hist[k-1];
    end
    hist[0].rsIn    = rs;
    hist[0].rst     = rs || dacRst_i;
    hist[0].mode    = mode_i;
    hist[0].sel     = sel_i;
    hist[0].direct  = direct_i;
    hist[0].trellis = trellis_i;
    hist[0].tSym    = trellisSym_i;
    hist[0].lSym    = legacySym_i;
    hist[0].rdStb   = hostReq_i.rdStb;
    hist[0].addr    = hostReq_i.addr;
    hist[0].arm     = rdArm_i;
    hist[0].rdExp   = rdExpect_i;
    hist[0].phErr   = phErrIn_i;
    if (rs) begin
      rsLeft  = 6;
      hitPipe = '0;
      for (int c = 0; c < 3; c++) begin
        expDac[c] = DacMidScale;
      end
    end else begin
      // Six cycles after rs, and three to eight cycles after a reset write
      expRst = (rsLeft > 0) || (|hitPipe[7:2]);
      if (rsLeft > 0) begin
        rsLeft--;
      end
      hitPipe = {hitPipe[6:0], hostReq_i.wrStb && (hostReq_i.addr == MiscResetAddr) && !expRst};
      compare("dacRst_o", dacRst_i, expRst);
      if (!hist[1].rsIn) begin
        compare("rdValid_o", rdValid_i, hist[1].rdStb);
        compare("phase error outputs", phErrOut_i, hist[1].phErr);
      end
      if (hist[1].rdStb) begin
        compare("rdData_o", rdData_i, (hist[1].addr == MiscVersionAddr) ? VerNumber : '0);
      end
      if (hist[1].rdStb && hist[1].arm) begin
        compare("rdData_o against pattern", rdData_i, hist[1].rdExp);
      end
      for (int c = 0; c < 3; c++) begin
        trellisPath = (hist[3].sel[c] >= DacTrellisI) && (hist[3].sel[c] <= DacTrellisIndex)
                      && (hist[3].mode == ModeMultiH);
        if (hist[1].rst || hist[2].rst) begin
          expDac[c] = DacMidScale;
        end else if (!trellisPath) begin
          expDac[c] = offsetBinary(hist[3].direct[c]);
        end else if (hist[3].trellis[c][TrellisW]) begin
          expDac[c] = offsetBinary(hist[3].trellis[c][TrellisW-1 -: DacW]);
        end
        compare($sformatf("dac%0d_o", c), dac_i[c], expDac[c]);
      end
      // Trellis two cycles back, legacy three
      if (hist[1].rst) begin
        expSym = '0;
      end else if (hist[2].mode == ModeMultiH) begin
        expSym = hist[2].tSym;
      end else begin
        expSym = hist[2].rst ? 4'h0 : hist[3].lSym;
      end
      compare("decSym_o", decSym_i, expSym);
    end
  end

endmodule

`default_nettype wire

/* verif/multihTb.sv */
// Testbench top with clock, reset, pattern records, random data and watchdog
`timescale 1ns/1ns
`default_nettype none

module multihTb;
  import demodPkg::*;

  typedef struct packed {
    logic [3:0]       op;       // 1 read, 2 write, 3 random run
    logic [3:0]       mode;
    logic [3:0]       sel;
    logic [AddrW-1:0] addr;
    logic [15:0]      cycles;
    logic [DataW-1:0] rdExp;
  } record_t;

  logic ck933;
  logic rs;
  hostReq_t hostReq;
  demodMode_e mode;
  dacSource_e sel [3];
  logic [2:0][DacW-1:0] dacData;
  logic [2:0][TrellisW:0] trellis;
  decSymbol_t trellisSym;
  decSymbol_t legacySym;
  logic [PhErrW-1:0] phaseErr;
  logic phaseErrEn;
  logic phaseErrValid;
  logic rdArm;
  logic [DataW-1:0] rdExpect;
  wire [DataW-1:0] rdData;
  wire rdValid;
  wire dacRst;
  wire [2:0][DacW-1:0] dacOut;
  wire [3:0] decSym;
  wire [PhErrW-1:0] phaseErrOut;
  wire phaseErrEnOut;
  wire phaseErrValidOut;
  int errCount;
  int checkCount;
  record_t records [0:63];
  int numRec;
  logic loaded;
  logic [31:0] rngState;

  always #20 ck933 = ~ck933;

  multihTop i_multihTop (
    .ck933(ck933), .rs(rs), .hostReq_i(hostReq), .demodMode_i(mode),
    .dac0Select_i(sel[0]), .dac1Select_i(sel[1]), .dac2Select_i(sel[2]),
    .dac0Data_i(dacData[0]), .dac1Data_i(dacData[1]), .dac2Data_i(dacData[2]),
    .trellis0_i(trellis[0]), .trellis1_i(trellis[1]), .trellis2_i(trellis[2]),
    .trellisSym_i(trellisSym), .legacySym_i(legacySym),
    .phaseErr_i(phaseErr), .phaseErrEn_i(phaseErrEn), .phaseErrValid_i(phaseErrValid),
    .rdData_o(rdData), .rdValid_o(rdValid), .dacRst_o(dacRst),
    .dac0_o(dacOut[0]), .dac1_o(dacOut[1]), .dac2_o(dacOut[2]), .decSym_o(decSym),
    .phaseErr_o(phaseErrOut), .phaseErrEn_o(phaseErrEnOut),
    .phaseErrValid_o(phaseErrValidOut)
  );

  multihChecker i_multihChecker (
    .ck933(ck933), .rs(rs), .hostReq_i(hostReq), .mode_i(mode),
    .sel_i({sel[2], sel[1], sel[0]}), .direct_i(dacData), .trellis_i(trellis),
    .trellisSym_i(trellisSym), .legacySym_i(legacySym),
    .phErrIn_i({phaseErrEn, phaseErrValid, phaseErr}), .rdArm_i(rdArm),
    .rdExpect_i(rdExpect), .rdData_i(rdData), .rdValid_i(rdValid), .dacRst_i(dacRst),
    .dac_i(dacOut), .decSym_i(decSym),
    .phErrOut_i({phaseErrEnOut, phaseErrValidOut, phaseErrOut}),
    .errCount_o(errCount), .checkCount_o(checkCount)
  );

  // Xorshift32
  function logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  task automatic randomizeData();
    logic [31:0] r;
    for (int c = 0; c < 3; c++) begin
      r          = nextRandom();
      dacData[c] = r[DacW-1:0];
      r          = nextRandom();
      trellis[c] = r[TrellisW:0];   // Sync is bit 18
    end
    r = nextRandom();
    {trellisSym, legacySym, phaseErrEn, phaseErrValid, phaseErr} = r[PhErrW+9:0];
  endtask

  task automatic loadRecords();
    int fd;
    int n;
    logic [31:0] f [6];
    logic [8*120-1:0] line;
    fd = $fopen("verif/multihPatterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the pattern file verif/multihPatterns.txt");
      $display("Result: FAILED");
      $finish;
    end
    while (!$feof(fd) && numRec < 64) begin
      line = '0;
      n = $fgets(line, fd);
      // Comment and blank lines do not scan
      n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
      if (n == 6) begin
        records[numRec] = {f[0][3:0], f[1][3:0], f[2][3:0], f[3][11:0], f[4][15:0], f[5][15:0]};
        numRec++;
      end
    end
    $fclose(fd);
  endtask

  task automatic applyRecord(input record_t rec);
    logic [31:0] r;
    mode = demodMode_e'(rec.mode);
    for (int c = 0; c < 3; c++) begin
      sel[c] = dacSource_e'(rec.sel);
    end
    randomizeData();
    if (rec.op == 4'h1 || rec.op == 4'h2) begin
      hostReq.rdStb  = (rec.op == 4'h1);
      hostReq.wrStb  = (rec.op == 4'h2);
      hostReq.addr   = rec.addr;
      r              = nextRandom();
      hostReq.wrData = r[DataW-1:0];
      rdArm          = (rec.op == 4'h1);
      rdExpect       = rec.rdExp;
      @(negedge ck933);
      hostReq = '0;
      rdArm   = 1'b0;
    end else begin
      repeat (rec.cycles) begin
        @(negedge ck933);
        randomizeData();
      end
    end
  endtask

  initial begin
    ck933 = 1'b0;
    rs = 1'b1;
    hostReq = '0;
    mode = ModeLegacy;
    sel = '{DacDirect, DacDirect, DacDirect};
    dacData = '0;
    trellis = '0;
    trellisSym = '0;
    legacySym = '0;
    phaseErr = '0;
    phaseErrEn = 1'b0;
    phaseErrValid = 1'b0;
    rdArm = 1'b0;
    rdExpect = '0;
    rngState = 32'h39083c77;
    numRec = 0;
    loaded = 1'b0;
    loadRecords();
    loaded = 1'b1;
    repeat (16) @(posedge ck933);
    @(negedge ck933);
    rs = 1'b0;
    for (int r = 0; r < numRec; r++) begin
      applyRecord(records[r]);
    end
    repeat (12) @(negedge ck933);
    $display("Records: %0d, checks: %0d, errors: %0d", numRec, checkCount, errCount);
    if (errCount == 0 && checkCount > 0 && numRec > 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

  // Watchdog sized from the record count
  initial begin
    wait (loaded);
    repeat (16 + numRec * 20 + 400) @(posedge ck933);
    $display("Timeout: the run did not finish within %0d clock periods",
             16 + numRec * 20 + 400);
    $display("Result: FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* verif/multihPatterns.txt */
# Directed records, every field in hex
# op (1 read, 2 write, 3 random run)  mode  select  addr  cycles  expected-read-data
3 0 0 000 10 0000
1 0 0 002 1 010e
1 0 0 004 1 0000
1 0 0 000 1 0000
3 0 0 000 20 0000
3 0 1 000 20 0000
3 8 0 000 20 0000
3 8 1 000 30 0000
3 8 4 000 30 0000
2 8 0 000 1 0000
3 8 2 000 20 0000
3 3 3 000 20 0000
1 8 0 002 1 010e
2 0 0 000 1 0000
3 0 0 000 10 0000
3 8 3 000 20 0000
1 0 0 7fc 1 0000

/* verilog.f */
rtl/demodPkg.sv
rtl/hostRegs.sv
rtl/resetStretch.sv
rtl/dacChannel.sv
rtl/decoderInSel.sv
rtl/multihTop.sv
verif/multihChecker.sv
verif/multihTb.sv
